// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing -j 0
TOP       ?= tb_int_exec_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/core_params_pkg.sv
package core_params_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int IMM_W      = 12;

    // physical register tags
    localparam int PREG_COUNT = 32;
    localparam int PREG_IDX   = 5;

    //////////////////////////////////////////////////////////////////////
    // queue and rob sizing
    //////////////////////////////////////////////////////////////////////

    localparam int IQ_DEPTH   = 8;
    // one extra bit so the top pointer can reach IQ_DEPTH
    localparam int IQ_IDX     = 4;
    localparam int ROB_IDX    = 6;

endpackage

// File: design/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage
import core_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          in_valid,
    input  dispatch_uop_t in_uop,
    output logic          in_ready,

    output logic          disp_valid,
    output iq_entry_t     disp_entry,
    input  logic          disp_ready,

    input  logic          cdb_fire,
    input  cdb_t          cdb
);

    // one bit per physical tag, set while a producer is in flight
    logic [PREG_COUNT-1:0] busy_q;
    logic                  accept;
    logic                  rs1_fwd;
    logic                  rs2_fwd;

    assign in_ready   = disp_ready;
    assign disp_valid = in_valid;
    assign accept     = in_valid & disp_ready;

    //////////////////////////////////////////////////////////////////////
    // source readiness
    //////////////////////////////////////////////////////////////////////

    // completion in this same cycle counts as ready
    assign rs1_fwd = cdb_fire && (cdb.rd_phy == in_uop.rs1_phy);
    assign rs2_fwd = cdb_fire && (cdb.rd_phy == in_uop.rs2_phy);

    always_comb begin
        disp_entry.uop     = in_uop;
        disp_entry.rs1_rdy = ~busy_q[in_uop.rs1_phy] | rs1_fwd;
        // immediate form never reads rs2
        disp_entry.rs2_rdy = ~busy_q[in_uop.rs2_phy] | rs2_fwd
                           | (in_uop.op2_sel == OP2_IMM);
    end

    //////////////////////////////////////////////////////////////////////
    // busy table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (cdb_fire) begin
                busy_q[cdb.rd_phy] <= 1'b0;
            end
            // a new producer wins over an old completion on the same tag
            if (accept) begin
                busy_q[in_uop.rd_phy] <= 1'b1;
            end
        end
    end

endmodule

// File: design/int_alu.sv
`timescale 1ns/1ps

module int_alu
import core_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    issue_valid,
    input  alu_in_t issue_data,
    output logic    alu_ready,

    output logic    out_valid,
    output cdb_t    out_result,
    input  logic    out_ready
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            load;

    // free when empty or when the held result leaves this cycle
    assign alu_ready = ~out_valid | out_ready;
    assign load      = issue_valid & alu_ready;

    assign op_a = issue_data.rs1_value;
    assign op_b = (issue_data.op2_sel == OP2_IMM)
                ? {{(XLEN-IMM_W){issue_data.imm[IMM_W-1]}}, issue_data.imm}
                : issue_data.rs2_value;

    always_comb begin
        unique case (issue_data.op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLL: result = op_a << op_b[4:0];
            ALU_SRL: result = op_a >> op_b[4:0];
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held steady while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_result.rob_id <= issue_data.rob_id;
            out_result.rd_phy <= issue_data.rd_phy;
            out_result.value  <= result;
        end
    end

endmodule

// File: design/int_exec_top.sv
`timescale 1ns/1ps

module int_exec_top
import core_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          in_valid,
    input  dispatch_uop_t in_uop,
    output logic          in_ready,

    output logic          out_valid,
    output cdb_t          out_result,
    input  logic          out_ready
);

    logic                disp_valid;
    iq_entry_t           disp_entry;
    logic                disp_ready;
    logic [PREG_IDX-1:0] rs1_phy;
    logic [PREG_IDX-1:0] rs2_phy;
    logic [XLEN-1:0]     rs1_value;
    logic [XLEN-1:0]     rs2_value;
    logic                issue_valid;
    alu_in_t             issue_data;
    logic                alu_ready;
    logic                cdb_fire;

    // completion bus is the output handshake
    assign cdb_fire = out_valid & out_ready;

    dispatch_stage dispatch_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .disp_valid (disp_valid),
        .disp_entry (disp_entry),
        .disp_ready (disp_ready),
        .cdb_fire   (cdb_fire),
        .cdb        (out_result)
    );

    int_issue_queue issue_queue_i (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_entry  (disp_entry),
        .disp_ready  (disp_ready),
        .cdb_fire    (cdb_fire),
        .cdb         (out_result),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .alu_ready   (alu_ready)
    );

    phys_regfile regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .cdb_fire  (cdb_fire),
        .cdb       (out_result)
    );

    int_alu alu_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .alu_ready   (alu_ready),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_ready   (out_ready)
    );

endmodule

// File: design/int_issue_queue.sv
`timescale 1ns/1ps

module int_issue_queue
import core_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                disp_valid,
    input  iq_entry_t           disp_entry,
    output logic                disp_ready,

    input  logic                cdb_fire,
    input  cdb_t                cdb,

    output logic [PREG_IDX-1:0] rs1_phy,
    output logic [PREG_IDX-1:0] rs2_phy,
    input  logic [XLEN-1:0]     rs1_value,
    input  logic [XLEN-1:0]     rs2_value,

    output logic                issue_valid,
    output alu_in_t             issue_data,
    input  logic                alu_ready
);

    iq_entry_t           iq_q [IQ_DEPTH];
    iq_entry_t           iq_d [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] valid_q;
    logic [IQ_DEPTH-1:0] valid_d;
    logic [IQ_IDX-1:0]   top_q;
    logic [IQ_IDX-1:0]   top_d;

    // one extra empty slot above the top so the shift has a source
    iq_entry_t           woken [IQ_DEPTH+1];
    logic [IQ_DEPTH:0]   valid_ext;

    logic [IQ_DEPTH-1:0] request;
    iq_entry_t           sel_entry;
    logic [IQ_IDX-1:0]   sel_idx;
    logic                pop_en;
    logic                push_en;
    logic [IQ_IDX-1:0]   push_idx;
    iq_sel_e             update_sel [IQ_DEPTH];

    //////////////////////////////////////////////////////////////////////
    // wakeup and oldest-ready select
    //////////////////////////////////////////////////////////////////////

    always_comb begin : wakeup
        for (int i = 0; i < IQ_DEPTH; i++) begin
            woken[i] = iq_q[i];
            if (cdb_fire && (iq_q[i].uop.rs1_phy == cdb.rd_phy)) begin
                woken[i].rs1_rdy = 1'b1;
            end
            if (cdb_fire && (iq_q[i].uop.rs2_phy == cdb.rd_phy)) begin
                woken[i].rs2_rdy = 1'b1;
            end
            request[i] = valid_q[i] & iq_q[i].rs1_rdy & iq_q[i].rs2_rdy;
        end
        woken[IQ_DEPTH] = '0;
    end

    assign valid_ext = {1'b0, valid_q};

    // slot 0 is always the oldest
    always_comb begin : select
        issue_valid = 1'b0;
        sel_idx     = '0;
        sel_entry   = iq_q[0];
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!issue_valid && request[i]) begin
                issue_valid = 1'b1;
                sel_idx     = IQ_IDX'(i);
                sel_entry   = iq_q[i];
            end
        end
    end

    assign rs1_phy = sel_entry.uop.rs1_phy;
    assign rs2_phy = sel_entry.uop.rs2_phy;

    always_comb begin
        issue_data.rob_id    = sel_entry.uop.rob_id;
        issue_data.rd_phy    = sel_entry.uop.rd_phy;
        issue_data.op        = sel_entry.uop.op;
        issue_data.op2_sel   = sel_entry.uop.op2_sel;
        issue_data.imm       = sel_entry.uop.imm;
        issue_data.rs1_value = rs1_value;
        issue_data.rs2_value = rs2_value;
    end

    //////////////////////////////////////////////////////////////////////
    // pop, push and compaction
    //////////////////////////////////////////////////////////////////////

    assign disp_ready = (top_q != IQ_IDX'(IQ_DEPTH));
    assign pop_en     = issue_valid & alu_ready;
    assign push_en    = disp_valid & disp_ready;
    // pop first, then push at the new top
    assign push_idx   = pop_en ? top_q - IQ_IDX'(1) : top_q;
    assign top_d      = push_idx + IQ_IDX'(push_en);

    always_comb begin : compress
        for (int i = 0; i < IQ_DEPTH; i++) begin
            update_sel[i] = IQ_KEEP;
            if (pop_en && valid_q[i] && (IQ_IDX'(i) >= sel_idx)) begin
                update_sel[i] = IQ_SHIFT;
            end
            if (push_en && (IQ_IDX'(i) == push_idx)) begin
                update_sel[i] = IQ_LOAD;
            end
            unique case (update_sel[i])
                IQ_SHIFT: begin
                    iq_d[i]    = woken[i+1];
                    valid_d[i] = valid_ext[i+1];
                end
                IQ_LOAD: begin
                    iq_d[i]    = disp_entry;
                    valid_d[i] = 1'b1;
                end
                default: begin
                    iq_d[i]    = woken[i];
                    valid_d[i] = valid_q[i];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            top_q   <= '0;
        end else begin
            valid_q <= valid_d;
            top_q   <= top_d;
        end
    end

    always_ff @(posedge clk) begin
        iq_q <= iq_d;
    end

endmodule

// File: design/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile
import core_params_pkg::*;
import uop_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic [PREG_IDX-1:0] rs1_phy,
    input  logic [PREG_IDX-1:0] rs2_phy,
    output logic [XLEN-1:0]     rs1_value,
    output logic [XLEN-1:0]     rs2_value,

    input  logic                cdb_fire,
    input  cdb_t                cdb
);

    logic [XLEN-1:0] regs [PREG_COUNT];

    // written from the completion bus only
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_fire) begin
            regs[cdb.rd_phy] <= cdb.value;
        end
    end

    // asynchronous reads, no write forwarding
    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

endmodule

// File: design/uop_types_pkg.sv
package uop_types_pkg;
    import core_params_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // second alu operand
    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    // renamed micro-op as it arrives
    typedef struct packed {
        logic [ROB_IDX-1:0]  rob_id;
        logic [PREG_IDX-1:0] rs1_phy;
        logic [PREG_IDX-1:0] rs2_phy;
        logic [PREG_IDX-1:0] rd_phy;
        alu_op_e             op;
        op2_sel_e            op2_sel;
        logic [IMM_W-1:0]    imm;
    } dispatch_uop_t;

    typedef struct packed {
        dispatch_uop_t uop;
        logic          rs1_rdy;
        logic          rs2_rdy;
    } iq_entry_t;

    // operands already read from the register file
    typedef struct packed {
        logic [ROB_IDX-1:0]  rob_id;
        logic [PREG_IDX-1:0] rd_phy;
        alu_op_e             op;
        op2_sel_e            op2_sel;
        logic [IMM_W-1:0]    imm;
        logic [XLEN-1:0]     rs1_value;
        logic [XLEN-1:0]     rs2_value;
    } alu_in_t;

    typedef struct packed {
        logic [ROB_IDX-1:0]  rob_id;
        logic [PREG_IDX-1:0] rd_phy;
        logic [XLEN-1:0]     value;
    } cdb_t;

    // per-slot update of the compacting queue
    typedef enum logic [1:0] {
        IQ_KEEP  = 2'd0,
        IQ_SHIFT = 2'd1,
        IQ_LOAD  = 2'd2
    } iq_sel_e;

endpackage

// File: project.f
+incdir+verification
design/core_params_pkg.sv
design/uop_types_pkg.sv
design/dispatch_stage.sv
design/int_issue_queue.sv
design/phys_regfile.sv
design/int_alu.sv
design/int_exec_top.sv
verification/tb_int_exec_top.sv

// File: verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int ROB_COUNT = 1 << ROB_IDX;

// register values in program order, updated at acceptance
logic [XLEN-1:0] model_regs [PREG_COUNT];
cdb_t            exp_result [ROB_COUNT];
dispatch_uop_t   uop_mem    [ROB_COUNT];
bit              pending    [ROB_COUNT];
// rob id of each source producer, -1 when it was already done
int              dep_rob    [ROB_COUNT][2];

// in-flight readers and writers of every tag
int              tag_use    [PREG_COUNT];
bit              write_live [PREG_COUNT];
int              writer_rob [PREG_COUNT];

int              inflight;
int              err_count;
bit              check_order;
int              order_q [$];

function automatic logic [XLEN-1:0] model_alu(alu_op_e op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a + ~b + XLEN'(1);
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_SLL: return a << sh;
        ALU_SRL: return a >> sh;
        // signed less-than, sign bits decide when they differ
        default: return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
    endcase
endfunction

task automatic reset_model();
    for (int i = 0; i < PREG_COUNT; i++) begin
        model_regs[i] = '0;
        tag_use[i]    = 0;
        write_live[i] = 1'b0;
        writer_rob[i] = 0;
    end
    for (int i = 0; i < ROB_COUNT; i++) begin
        pending[i] = 1'b0;
    end
    inflight    = 0;
    check_order = 1'b0;
    order_q.delete();
endtask

task automatic check_result(string name, cdb_t got, cdb_t exp);
    if (got !== exp) begin
        $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        err_count++;
    end
endtask

task automatic check_flow(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
        err_count++;
    end
endtask

task automatic accept_uop(dispatch_uop_t u);
    int              rid;
    logic [XLEN-1:0] b;
    rid = int'(u.rob_id);
    if (pending[rid]) begin
        $display("At %0d ns rob id %0d was accepted while still in flight", $time, rid);
        err_count++;
    end
    b = (u.op2_sel == OP2_IMM) ? XLEN'($signed(u.imm)) : model_regs[u.rs2_phy];
    exp_result[rid].rob_id = u.rob_id;
    exp_result[rid].rd_phy = u.rd_phy;
    exp_result[rid].value  = model_alu(u.op, model_regs[u.rs1_phy], b);
    dep_rob[rid][0] = write_live[u.rs1_phy] ? writer_rob[u.rs1_phy] : -1;
    dep_rob[rid][1] = (u.op2_sel == OP2_RS2 && write_live[u.rs2_phy])
                    ? writer_rob[u.rs2_phy] : -1;
    model_regs[u.rd_phy] = exp_result[rid].value;
    tag_use[u.rs1_phy]++;
    tag_use[u.rs2_phy]++;
    tag_use[u.rd_phy]++;
    write_live[u.rd_phy] = 1'b1;
    writer_rob[u.rd_phy] = rid;
    uop_mem[rid] = u;
    pending[rid] = 1'b1;
    inflight++;
    if (check_order) begin
        order_q.push_back(rid);
    end
endtask

task automatic complete_uop(cdb_t got);
    int            rid;
    int            oldest;
    dispatch_uop_t u;
    rid = int'(got.rob_id);
    if (!pending[rid]) begin
        $display("At %0d ns rob id %0d completed but was not in flight", $time, rid);
        err_count++;
        return;
    end
    for (int k = 0; k < 2; k++) begin
        if (dep_rob[rid][k] >= 0 && pending[dep_rob[rid][k]]) begin
            $display("At %0d ns rob id %0d completed before its producer rob id %0d",
                     $time, rid, dep_rob[rid][k]);
            err_count++;
        end
    end
    check_result("out_result", got, exp_result[rid]);
    if (check_order) begin
        oldest = order_q.pop_front();
        check_result("out_result in age order", got, exp_result[oldest]);
    end
    u = uop_mem[rid];
    tag_use[u.rs1_phy]--;
    tag_use[u.rs2_phy]--;
    tag_use[u.rd_phy]--;
    write_live[u.rd_phy] = 1'b0;
    pending[rid] = 1'b0;
    inflight--;
endtask

`endif

// File: verification/tb_int_exec_top.sv
`timescale 1ns/1ps

module tb_int_exec_top
import core_params_pkg::*;
import uop_types_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int TOTAL_UOPS  = 16 + 40 + 200 + IQ_DEPTH + 1 + 24;
    localparam int DRAIN_LIMIT = 2000;

    // how the stream picks its tags
    localparam int MODE_SWEEP = 0;
    localparam int MODE_ANY   = 1;
    localparam int MODE_INDEP = 2;
    localparam int MODE_CHAIN = 3;

    logic                clk;
    logic                rst;
    logic                in_valid;
    dispatch_uop_t       in_uop;
    logic                in_ready;
    logic                out_valid;
    cdb_t                out_result;
    logic                out_ready;

    logic [31:0]         lfsr_state;
    bit                  accepted;
    bit                  stall_prev;
    cdb_t                held_result;
    logic [PREG_IDX-1:0] last_rd;
    logic [ROB_IDX-1:0]  next_rob;
    int                  tests_failed;

    `include "tb_ref_model.svh"

    int_exec_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_ready  (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////////////////////////

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic bit lfsr_bit();
        bit b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // free tag for a destination, or a tag no in-flight op writes
    function automatic logic [PREG_IDX-1:0] pick_tag(bit for_dest);
        logic [PREG_IDX-1:0] t;
        t = PREG_IDX'(rand_bits(PREG_IDX));
        for (int i = 0; i < PREG_COUNT; i++) begin
            if (for_dest ? (tag_use[t] == 0) : !write_live[t]) begin
                return t;
            end
            t = t + 1'b1;
        end
        return t;
    endfunction

    function automatic dispatch_uop_t next_uop(int mode, int idx);
        dispatch_uop_t u;
        u.rob_id  = next_rob;
        u.rs1_phy = (mode == MODE_INDEP) ? pick_tag(1'b0) : PREG_IDX'(rand_bits(PREG_IDX));
        u.rs2_phy = (mode == MODE_INDEP) ? pick_tag(1'b0) : PREG_IDX'(rand_bits(PREG_IDX));
        if (mode == MODE_CHAIN) begin
            u.rs1_phy = last_rd;
        end
        u.rd_phy  = pick_tag(1'b1);
        u.op      = alu_op_e'(3'(rand_bits(3)));
        u.op2_sel = op2_sel_e'(1'(rand_bits(1)));
        if (mode == MODE_SWEEP) begin
            u.op      = alu_op_e'(idx[3:1]);
            u.op2_sel = op2_sel_e'(idx[0]);
        end
        u.imm = IMM_W'(rand_bits(IMM_W));
        return u;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // cycle step and monitor
    //////////////////////////////////////////////////////////////////////

    // samples the handshakes of the edge before any register updates
    task automatic tick();
        @(posedge clk);
        accepted = 1'b0;
        if (!rst) begin
            if (stall_prev) begin
                check_flow("out_valid", out_valid, 1'b1);
                check_result("out_result", out_result, held_result);
            end
            if (out_valid && out_ready) begin
                complete_uop(out_result);
            end
            if (in_valid && in_ready) begin
                accept_uop(in_uop);
                accepted = 1'b1;
                last_rd  = in_uop.rd_phy;
                next_rob = next_rob + 1'b1;
            end
            stall_prev  = out_valid && !out_ready;
            held_result = out_result;
        end
    endtask

    task automatic apply_reset();
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        reset_model();
        stall_prev = 1'b0;
        next_rob   = '0;
        last_rd    = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic drain(string name);
        int n;
        n = 0;
        while (inflight > 0 && n < DRAIN_LIMIT) begin
            tick();
            n++;
        end
        if (inflight > 0) begin
            $display("%s: %0d micro-ops never completed", name, inflight);
            err_count++;
        end
    endtask

    task automatic report_test(string name, int n, int errs_before);
        int errs;
        errs = err_count - errs_before;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%s: %0d micro-ops, %0d errors", name, n, errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic run_stream(string name, int n, int mode, bit rnd_valid, bit rnd_ready);
        int sent;
        int errs_before;
        sent        = 0;
        errs_before = err_count;
        check_order = (mode == MODE_INDEP);
        order_q.delete();
        in_uop    <= next_uop(mode, 0);
        in_valid  <= !rnd_valid || rand_bits(2) != 0;
        out_ready <= !rnd_ready || rand_bits(1) != 0;
        while (sent < n) begin
            tick();
            if (accepted) begin
                sent++;
            end
            // hold an offered op until it is taken
            if (accepted || !in_valid) begin
                in_uop   <= next_uop(mode, sent);
                in_valid <= (sent < n) && (!rnd_valid || rand_bits(2) != 0);
            end
            if (rnd_ready) begin
                out_ready <= rand_bits(1) != 0;
            end
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        drain(name);
        report_test(name, sent, errs_before);
    endtask

    task automatic run_full_queue();
        int count;
        int n;
        int errs_before;
        count       = 0;
        n           = 0;
        errs_before = err_count;
        check_order = 1'b1;
        order_q.delete();
        out_ready <= 1'b0;
        in_uop    <= next_uop(MODE_INDEP, 0);
        in_valid  <= 1'b1;
        while (n < 4 * IQ_DEPTH) begin
            tick();
            n++;
            if (accepted) begin
                count++;
                in_uop <= next_uop(MODE_INDEP, count);
            end else if (!in_ready) begin
                break;
            end
        end
        if (count != IQ_DEPTH + 1) begin
            $display("full_queue: %0d micro-ops accepted before in_ready fell, %0d expected",
                     count, IQ_DEPTH + 1);
            err_count++;
        end
        repeat (3) begin
            tick();
            check_flow("in_ready", in_ready, 1'b0);
        end
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        drain("full_queue");
        report_test("full_queue", count, errs_before);
    endtask

    task automatic run_reset_state();
        int errs_before;
        errs_before = err_count;
        apply_reset();
        tick();
        check_flow("in_ready", in_ready, 1'b1);
        check_flow("out_valid", out_valid, 1'b0);
        report_test("reset_state", 0, errs_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_uop       = '0;
        out_ready    = 1'b0;
        lfsr_state   = 32'h354f_72b0;
        err_count    = 0;
        tests_failed = 0;
        apply_reset();
        run_stream("dep_chain", 40, MODE_CHAIN, 1'b1, 1'b0);
        run_stream("random_mix", 200, MODE_ANY, 1'b1, 1'b1);
        // registers hold mixed values by now, so every opcode sees real operands
        run_stream("op_sweep", 16, MODE_SWEEP, 1'b0, 1'b0);
        run_full_queue();
        run_reset_state();
        run_stream("age_order", 24, MODE_INDEP, 1'b0, 1'b1);
        $display("tests run 6, failed %0d, errors %0d", tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // generous bound of 200 cycles per micro-op
    initial begin
        #(TOTAL_UOPS * 200 * CLK_PERIOD);
        $display("watchdog: the run timed out after %0d cycles", TOTAL_UOPS * 200);
        $display("Test FAILED");
        $finish;
    end

endmodule
